//--- logic/uartPkg.sv
// uartPkg: serial line timing and frame format constants

package uartPkg;

	// frame format, 8N1
	localparam int DATA_BITS = 8;

	// receiver and transmitter both run on the 16x tick
	localparam int OVERSAMPLE = 16;

	// clocks per oversampling tick
	// kept tiny so one bit is only 64 clocks in simulation
	localparam int BAUD_DIVISOR = 4;

	localparam int DIVISOR_WIDTH = $clog2(BAUD_DIVISOR);

endpackage

//--- logic/debugPkg.sv
// debugPkg: register file geometry and debug command opcodes

package debugPkg;

	// processor register file as seen by the debug unit
	localparam int REG_COUNT = 32;
	localparam int REG_WIDTH = 32;
	localparam int BYTES_PER_REG = 4;
	localparam int BYTE_WIDTH = REG_WIDTH / BYTES_PER_REG;

	localparam int REG_INDEX_WIDTH = 5;
	localparam int BYTE_INDEX_WIDTH = 2;

	// command byte is {opcode[2:0], regIndex[4:0]}
	localparam int OPCODE_WIDTH = 3;

	localparam logic [OPCODE_WIDTH-1:0] OP_STEP = 3'd1;  // single step pulse
	localparam logic [OPCODE_WIDTH-1:0] OP_DUMP = 3'd2;  // all registers
	localparam logic [OPCODE_WIDTH-1:0] OP_READ = 3'd3;  // one register, index in low bits

endpackage

//--- logic/debugIfs.sv
// txCtrlIf and snapIf: controller links to the transmitter and the register snapshot
`timescale 1ns/1ps

// one byte per start strobe, done pulses after the stop bit
interface txCtrlIf
	import debugPkg::*;
();
	logic start;
	logic [BYTE_WIDTH-1:0] data;
	logic busy;
	logic done;

	modport ctrl (output start, output data, input busy, input done);
	modport serializer (input start, input data, output busy, output done);
endinterface

// capture latches all registers, byteOut is read back combinationally
interface snapIf
	import debugPkg::*;
();
	logic capture;
	logic [REG_INDEX_WIDTH-1:0] regIndex;
	logic [BYTE_INDEX_WIDTH-1:0] byteIndex;
	logic [BYTE_WIDTH-1:0] byteOut;

	modport ctrl (output capture, output regIndex, output byteIndex, input byteOut);
	modport store (input capture, input regIndex, input byteIndex, output byteOut);
endinterface

//--- logic/baudTickGen.sv
// baudTickGen: free running divider giving the 16x oversampling tick
`timescale 1ns/1ps

module baudTickGen
	import uartPkg::*;
(
	input  logic clk,
	input  logic reset,
	output logic tick
);

	logic [DIVISOR_WIDTH-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			tick <= 1'b0;
		end else if (count == DIVISOR_WIDTH'(BAUD_DIVISOR - 1)) begin
			count <= '0;
			tick <= 1'b1;  // one clock wide
		end else begin
			count <= count + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

//--- logic/uartReceiver.sv
// uartReceiver: rx synchronizer, start edge detect and mid-bit sampling FSM
`timescale 1ns/1ps

module uartReceiver
	import uartPkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 rx,
	input  logic                 tick,
	output logic [DATA_BITS-1:0] rxByte,
	output logic                 rxValid
);

	logic [1:0] rxSync;  // two flop synchronizer
	logic rxLast;        // previous synced level, for the falling edge
	logic [$clog2(OVERSAMPLE)-1:0] tickCount;
	logic [$clog2(DATA_BITS)-1:0] bitCount;
	logic [DATA_BITS-1:0] shiftReg;
	enum logic [1:0] {IDLE, START, DATA, STOP} state;

	// line idles high
	always_ff @(posedge clk) begin
		if (reset) begin
			rxSync <= 2'b11;
			rxLast <= 1'b1;
		end else begin
			rxSync <= {rxSync[0], rx};
			rxLast <= rxSync[1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			tickCount <= '0;
			bitCount <= '0;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			case (state)
				IDLE: if (rxLast && !rxSync[1]) begin
					tickCount <= '0;
					state <= START;
				end
				START: if (tick) begin
					if (tickCount == OVERSAMPLE / 2 - 1) begin
						// still low at mid start bit, else it was a glitch
						tickCount <= '0;
						bitCount <= '0;
						state <= rxSync[1] ? IDLE : DATA;
					end else
						tickCount <= tickCount + 1'b1;
				end
				DATA: if (tick) begin
					if (tickCount == OVERSAMPLE - 1) begin
						tickCount <= '0;
						shiftReg <= {rxSync[1], shiftReg[DATA_BITS-1:1]};  // lsb first
						if (bitCount == DATA_BITS - 1)
							state <= STOP;
						else
							bitCount <= bitCount + 1'b1;
					end else
						tickCount <= tickCount + 1'b1;
				end
				STOP: if (tick) begin
					if (tickCount == OVERSAMPLE - 1) begin
						rxValid <= rxSync[1];  // framing error drops the byte
						state <= IDLE;
					end else
						tickCount <= tickCount + 1'b1;
				end
			endcase
		end
	end

	assign rxByte = shiftReg;

endmodule

//--- logic/uartTransmitter.sv
// uartTransmitter: 8N1 serializer loaded by a start strobe
`timescale 1ns/1ps

module uartTransmitter
	import uartPkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          tick,
	output logic          tx,
	txCtrlIf.serializer   txCtrl
);

	logic [$clog2(OVERSAMPLE)-1:0] tickCount;
	logic [$clog2(DATA_BITS)-1:0] bitCount;
	logic [DATA_BITS-1:0] shiftReg;
	enum logic [1:0] {IDLE, START, DATA, STOP} state;

	// drops together with the done pulse
	assign txCtrl.busy = (state != IDLE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			tickCount <= '0;
			bitCount <= '0;
			tx <= 1'b1;
			txCtrl.done <= 1'b0;
		end else begin
			txCtrl.done <= 1'b0;
			case (state)
				IDLE: if (txCtrl.start) begin
					shiftReg <= txCtrl.data;
					tickCount <= '0;
					tx <= 1'b0;  // start bit
					state <= START;
				end
				START: if (tick) begin
					if (tickCount == OVERSAMPLE - 1) begin
						tickCount <= '0;
						bitCount <= '0;
						tx <= shiftReg[0];
						state <= DATA;
					end else
						tickCount <= tickCount + 1'b1;
				end
				DATA: if (tick) begin
					if (tickCount == OVERSAMPLE - 1) begin
						tickCount <= '0;
						shiftReg <= shiftReg >> 1;
						if (bitCount == DATA_BITS - 1) begin
							tx <= 1'b1;  // stop bit
							state <= STOP;
						end else begin
							tx <= shiftReg[1];
							bitCount <= bitCount + 1'b1;
						end
					end else
						tickCount <= tickCount + 1'b1;
				end
				STOP: if (tick) begin
					if (tickCount == OVERSAMPLE - 1) begin
						txCtrl.done <= 1'b1;
						state <= IDLE;
					end else
						tickCount <= tickCount + 1'b1;
				end
			endcase
		end
	end

endmodule

//--- logic/registerSnapshot.sv
// registerSnapshot: one-shot copy of the register file and byte readout mux
`timescale 1ns/1ps

module registerSnapshot
	import debugPkg::*;
(
	input  logic                                 clk,
	input  logic [REG_COUNT-1:0][REG_WIDTH-1:0] regValues,
	snapIf.store                                 snap
);

	// same bit layout as regValues, split into bytes
	logic [REG_COUNT-1:0][BYTES_PER_REG-1:0][BYTE_WIDTH-1:0] latched;

	always_ff @(posedge clk) begin
		if (snap.capture)
			latched <= regValues;
	end

	// byte 0 is bits 7:0 of the selected register
	assign snap.byteOut = latched[snap.regIndex][snap.byteIndex];

endmodule

//--- logic/debugControl.sv
// debugControl: command decode, step pulse and register readout sequencer
`timescale 1ns/1ps

module debugControl
	import debugPkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic [BYTE_WIDTH-1:0] rxByte,
	input  logic                  rxValid,
	output logic                  stepPulse,
	txCtrlIf.ctrl                 txCtrl,
	snapIf.ctrl                   snap
);

	logic [OPCODE_WIDTH-1:0] opcode;
	logic [REG_INDEX_WIDTH-1:0] lastIndex;  // final register of the reply
	logic lastByte;
	enum logic [1:0] {IDLE, SEND, WAIT} state;

	assign opcode = rxByte[BYTE_WIDTH-1 -: OPCODE_WIDTH];
	assign lastByte = (snap.byteIndex == BYTE_INDEX_WIDTH'(BYTES_PER_REG - 1))
		&& (snap.regIndex == lastIndex);

	// serializer takes this on the start strobe
	assign txCtrl.data = snap.byteOut;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			stepPulse <= 1'b0;
			snap.capture <= 1'b0;
			snap.regIndex <= '0;
			snap.byteIndex <= '0;
			lastIndex <= '0;
			txCtrl.start <= 1'b0;
		end else begin
			stepPulse <= 1'b0;
			snap.capture <= 1'b0;
			txCtrl.start <= 1'b0;
			case (state)
				// new commands only taken here, anything during a reply is dropped
				IDLE: if (rxValid) begin
					case (opcode)
						OP_STEP: stepPulse <= 1'b1;
						OP_DUMP: begin
							snap.regIndex <= '0;
							lastIndex <= REG_INDEX_WIDTH'(REG_COUNT - 1);
							snap.byteIndex <= '0;
							snap.capture <= 1'b1;
							state <= SEND;
						end
						OP_READ: begin
							snap.regIndex <= rxByte[REG_INDEX_WIDTH-1:0];
							lastIndex <= rxByte[REG_INDEX_WIDTH-1:0];
							snap.byteIndex <= '0;
							snap.capture <= 1'b1;
							state <= SEND;
						end
						default: ;  // unused opcodes
					endcase
				end
				// snapshot is being latched this cycle
				SEND: if (!txCtrl.busy) begin
					txCtrl.start <= 1'b1;
					state <= WAIT;
				end
				WAIT: if (txCtrl.done) begin
					if (lastByte)
						state <= IDLE;
					else begin
						txCtrl.start <= 1'b1;  // busy already low with done
						snap.byteIndex <= snap.byteIndex + 1'b1;
						if (snap.byteIndex == BYTE_INDEX_WIDTH'(BYTES_PER_REG - 1))
							snap.regIndex <= snap.regIndex + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- logic/debugUnit.sv
// debugUnit: top level of the serial debug unit, UART blocks, snapshot and controller
`timescale 1ns/1ps

module debugUnit
	import debugPkg::*;
(
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 rx,
	input  logic [REG_COUNT-1:0][REG_WIDTH-1:0] regValues,
	output logic                                 tx,
	output logic [BYTE_WIDTH-1:0]                rxData,
	output logic                                 rxValid,
	output logic                                 stepPulse
);

	logic tick;  // shared 16x tick

	txCtrlIf txCtrl();
	snapIf snap();

	baudTickGen baudTickGen_i (
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	uartReceiver uartReceiver_i (
		.clk     (clk),
		.reset   (reset),
		.rx      (rx),
		.tick    (tick),
		.rxByte  (rxData),
		.rxValid (rxValid)
	);

	uartTransmitter uartTransmitter_i (
		.clk    (clk),
		.reset  (reset),
		.tick   (tick),
		.tx     (tx),
		.txCtrl (txCtrl.serializer)
	);

	registerSnapshot registerSnapshot_i (
		.clk       (clk),
		.regValues (regValues),
		.snap      (snap.store)
	);

	// received bytes also go straight out on rxData and rxValid
	debugControl debugControl_i (
		.clk       (clk),
		.reset     (reset),
		.rxByte    (rxData),
		.rxValid   (rxValid),
		.stepPulse (stepPulse),
		.txCtrl    (txCtrl.ctrl),
		.snap      (snap.ctrl)
	);

endmodule

//--- bench/debugUnitAssert.sv
// debugUnitAssert: concurrent checks on the debug unit strobes and tx, and its bind
`timescale 1ns/1ps

module debugUnitAssert (
	input logic clk,
	input logic reset,
	input logic tx,
	input logic stepPulse,
	input logic rxValid
);

	int failCount = 0;  // assertion failures so far

	property singleCycle(sig);
		@(posedge clk) disable iff (reset) sig |=> !sig;
	endproperty

	stepSingle: assert property (singleCycle(stepPulse))
		else begin
			$error("stepPulse high for two cycles in a row");
			failCount++;
		end

	validSingle: assert property (singleCycle(rxValid))
		else begin
			$error("rxValid high for two cycles in a row");
			failCount++;
		end

	// tx flop needs one reset edge first
	txIdleInReset: assert property (@(posedge clk) (reset ##1 reset) |-> tx)
		else begin
			$error("tx low while reset is held");
			failCount++;
		end

	stepAfterValid: assert property (@(posedge clk) disable iff (reset)
		$rose(stepPulse) |-> $past(rxValid))
		else begin
			$error("stepPulse rose without rxValid in the cycle before");
			failCount++;
		end

endmodule

bind debugUnit debugUnitAssert debugUnitAssert_i (
	.clk       (clk),
	.reset     (reset),
	.tx        (tx),
	.stepPulse (stepPulse),
	.rxValid   (rxValid)
);

//--- bench/tbDebugUnit.sv
// tbDebugUnit: clock, reset, serial host model, reference byte function and checks
`timescale 1ns/1ps

module tbDebugUnit
	import uartPkg::*, debugPkg::*;
();

	localparam int CLOCKS_PER_BIT = BAUD_DIVISOR * OVERSAMPLE;
	localparam int FRAME_CLOCKS = CLOCKS_PER_BIT * (DATA_BITS + 2);
	localparam int START_TIMEOUT = 3 * FRAME_CLOCKS;  // clocks to wait for a start bit

	logic clk = 1'b0;
	logic reset;
	logic rx;
	logic [REG_COUNT-1:0][REG_WIDTH-1:0] regValues;
	logic tx;
	logic [BYTE_WIDTH-1:0] rxData;
	logic rxValid;
	logic stepPulse;

	logic [31:0] lfsr = 32'h26a8_d211;
	logic [REG_COUNT-1:0][REG_WIDTH-1:0] heldRegs;  // regs at the end of the command
	logic [7:0] expQueue[$];
	logic [7:0] gotQueue[$];
	logic [7:0] expByte;
	logic [7:0] gotByte;
	logic [7:0] lastRxData;
	string testName = "none";
	int validCount = 0;
	int stepCount = 0;
	int mismatchCount = 0;
	int otherCount = 0;

	debugUnit debugUnit_i (
		.clk       (clk),
		.reset     (reset),
		.rx        (rx),
		.regValues (regValues),
		.tx        (tx),
		.rxData    (rxData),
		.rxValid   (rxValid),
		.stepPulse (stepPulse)
	);

	initial begin
		forever #10 clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] randomBits(input int width);
		logic [31:0] value;
		logic feedback;
		int i;
		value = '0;
		for (i = 0; i < width; i++) begin
			feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	// byte n of the reply is byte n mod 4 of register n div 4, lsb first
	function automatic logic [7:0] expectedByte(
		input logic [REG_COUNT-1:0][REG_WIDTH-1:0] regs, input int n);
		return regs[n / BYTES_PER_REG][8 * (n % BYTES_PER_REG) +: 8];
	endfunction

	task automatic randomizeRegs();
		int r;
		for (r = 0; r < REG_COUNT; r++)
			regValues[r] = randomBits(REG_WIDTH);
	endtask

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s %s expected %0h actual %0h", testName, what, expected, actual);
			mismatchCount++;
		end
	endtask

	// host side of the rx line, 8N1
	task automatic sendFrame(input logic [7:0] value, input logic stopBit);
		int i;
		rx = 1'b0;
		repeat (CLOCKS_PER_BIT) @(negedge clk);
		for (i = 0; i < DATA_BITS; i++) begin
			rx = value[i];
			repeat (CLOCKS_PER_BIT) @(negedge clk);
		end
		rx = stopBit;
		repeat (CLOCKS_PER_BIT) @(negedge clk);
		rx = 1'b1;
	endtask

	// returns in the middle of the stop bit
	task automatic receiveByte(output logic [7:0] value, output bit ok);
		int waitCount;
		int i;
		ok = 1'b0;
		value = '0;
		waitCount = 0;
		while (tx !== 1'b0 && waitCount < START_TIMEOUT) begin
			@(negedge clk);
			waitCount++;
		end
		if (tx !== 1'b0)
			return;
		repeat (CLOCKS_PER_BIT / 2) @(negedge clk);
		if (tx !== 1'b0)
			return;  // start bit too short
		for (i = 0; i < DATA_BITS; i++) begin
			repeat (CLOCKS_PER_BIT) @(negedge clk);
			value[i] = tx;
		end
		repeat (CLOCKS_PER_BIT) @(negedge clk);
		ok = (tx === 1'b1);
	endtask

	task automatic receiveBytes(input int count, input bit changeRegs);
		logic [7:0] value;
		bit ok;
		int n;
		for (n = 0; n < count; n++) begin
			receiveByte(value, ok);
			if (!ok) begin
				$display("%s: byte %0d of %0d never arrived as a good frame", testName, n, count);
				otherCount++;
				break;
			end
			gotQueue.push_back(value);
			if (n == 0 && changeRegs)
				randomizeRegs();  // later bytes must come from the snapshot
		end
	endtask

	task automatic checkQuietLine(input int cycles);
		int c;
		bit seen;
		seen = 1'b0;
		for (c = 0; c < cycles; c++) begin
			@(negedge clk);
			if (tx !== 1'b1)
				seen = 1'b1;
		end
		if (seen) begin
			$display("%s: tx went low when no reply was expected", testName);
			otherCount++;
		end
	endtask

	task automatic checkDrained();
		repeat (2) @(negedge clk);
		if (expQueue.size() != 0 || gotQueue.size() != 0) begin
			$display("%s: reply length wrong, %0d expected bytes missing, %0d extra bytes",
				testName, expQueue.size(), gotQueue.size());
			otherCount++;
		end
		expQueue.delete();
		gotQueue.delete();
	endtask

	// strobe counters
	initial begin
		forever begin
			@(negedge clk);
			if (rxValid === 1'b1) begin
				validCount++;
				lastRxData = rxData;
			end
			if (stepPulse === 1'b1)
				stepCount++;
		end
	end

	// compares reply bytes with the reference as they arrive
	initial begin
		forever begin
			@(negedge clk);
			while (expQueue.size() > 0 && gotQueue.size() > 0) begin
				expByte = expQueue.pop_front();
				gotByte = gotQueue.pop_front();
				if (gotByte !== expByte) begin
					$display("FAIL %s expected %02h actual %02h", testName, expByte, gotByte);
					mismatchCount++;
				end
			end
		end
	end

	initial begin : runTests
		int i;
		int validBefore;
		int stepBefore;
		int assertCount;
		logic [7:0] cmd;
		logic [7:0] stepCmd;
		logic [REG_INDEX_WIDTH-1:0] index;
		rx = 1'b1;
		reset = 1'b1;
		randomizeRegs();

		testName = "reset";
		repeat (16) begin
			@(negedge clk);
			if (tx !== 1'b1 || stepPulse !== 1'b0 || rxValid !== 1'b0) begin
				$display("reset: tx or a strobe had the wrong level during reset");
				otherCount++;
			end
		end
		reset = 1'b0;
		checkQuietLine(2 * FRAME_CLOCKS);
		checkValue("rxValid pulses", 0, validCount);
		checkValue("stepPulse pulses", 0, stepCount);

		testName = "echo";
		for (i = 0; i < 4; i++) begin
			cmd = {OP_STEP, 5'(randomBits(5))};
			validBefore = validCount;
			stepBefore = stepCount;
			sendFrame(cmd, 1'b1);
			repeat (4) @(negedge clk);
			checkValue("rxValid pulses", validBefore + 1, validCount);
			checkValue("rxData", cmd, lastRxData);
			checkValue("stepPulse pulses", stepBefore + 1, stepCount);
		end

		// full dump, with a step command arriving in the middle
		testName = "dump";
		cmd = {OP_DUMP, 5'(randomBits(5))};
		stepCmd = {OP_STEP, 5'(randomBits(5))};
		heldRegs = regValues;
		for (i = 0; i < REG_COUNT * BYTES_PER_REG; i++)
			expQueue.push_back(expectedByte(heldRegs, i));
		validBefore = validCount;
		stepBefore = stepCount;
		fork
			begin
				sendFrame(cmd, 1'b1);
				repeat (3 * FRAME_CLOCKS) @(negedge clk);
				sendFrame(stepCmd, 1'b1);
			end
			receiveBytes(REG_COUNT * BYTES_PER_REG, 1'b1);
		join
		checkDrained();
		checkQuietLine(2 * FRAME_CLOCKS);
		checkValue("rxValid pulses", validBefore + 2, validCount);
		checkValue("stepPulse pulses", stepBefore, stepCount);

		testName = "read";
		for (i = 0; i < 2; i++) begin
			index = REG_INDEX_WIDTH'(randomBits(REG_INDEX_WIDTH));
			heldRegs = regValues;
			for (int b = 0; b < BYTES_PER_REG; b++)
				expQueue.push_back(expectedByte(heldRegs, int'(index) * BYTES_PER_REG + b));
			fork
				sendFrame({OP_READ, index}, 1'b1);
				receiveBytes(BYTES_PER_REG, 1'b0);
			join
			checkDrained();
			checkQuietLine(2 * FRAME_CLOCKS);
		end

		testName = "ignored";
		cmd = {3'(3'd4 + randomBits(2)), 5'(randomBits(5))};  // opcodes 4 to 7
		validBefore = validCount;
		stepBefore = stepCount;
		fork
			sendFrame(cmd, 1'b1);
			checkQuietLine(3 * FRAME_CLOCKS);
		join
		checkValue("rxValid pulses", validBefore + 1, validCount);
		checkValue("rxData", cmd, lastRxData);
		checkValue("stepPulse pulses", stepBefore, stepCount);

		testName = "framing";
		validBefore = validCount;
		stepBefore = stepCount;
		sendFrame({OP_STEP, 5'(randomBits(5))}, 1'b0);
		repeat (CLOCKS_PER_BIT) @(negedge clk);
		checkValue("rxValid pulses", validBefore, validCount);
		checkValue("stepPulse pulses", stepBefore, stepCount);

		repeat (4) @(negedge clk);
		assertCount = debugUnit_i.debugUnitAssert_i.failCount;
		$display("summary: %0d value mismatches, %0d other errors, %0d assertion failures",
			mismatchCount, otherCount, assertCount);
		if (mismatchCount + otherCount + assertCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- verilog.f
logic/uartPkg.sv
logic/debugPkg.sv
logic/debugIfs.sv
logic/baudTickGen.sv
logic/uartReceiver.sv
logic/uartTransmitter.sv
logic/registerSnapshot.sv
logic/debugControl.sv
logic/debugUnit.sv
bench/debugUnitAssert.sv
bench/tbDebugUnit.sv

//--- Bender.yml
package:
  name: debug_unit

sources:
  - files:
      - logic/uartPkg.sv
      - logic/debugPkg.sv
      - logic/debugIfs.sv
      - logic/baudTickGen.sv
      - logic/uartReceiver.sv
      - logic/uartTransmitter.sv
      - logic/registerSnapshot.sv
      - logic/debugControl.sv
      - logic/debugUnit.sv
  - target: test
    files:
      - bench/debugUnitAssert.sv
      - bench/tbDebugUnit.sv
